// ==== Makefile ====
# Verilator build and run of the root-port VC endpoint testbench

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module rp_vc_intf_tb \
		-f rp_vc_intf.f --Mdir obj_dir -o rp_vc_intf_sim
	@out="$$(./obj_dir/rp_vc_intf_sim)"; echo "$$out"; \
		echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir

// ==== rp_vc_intf.f ====
rtl/rp_pkg.sv
rtl/target_mem.sv
rtl/rx_tlp_decoder.sv
rtl/cpl_req_fifo.sv
rtl/tx_cpl_builder.sv
rtl/rp_vc_intf.sv
tests/rp_vc_intf_sva.sv
tests/rp_vc_intf_tb.sv

// ==== rtl/cpl_req_fifo.sv ====
// Queue of pending completion requests, one entry per accepted read
// A push while full and a pop while empty are ignored
// Head fields are valid whenever not_empty is high
// An entry pushed on one edge shows as not_empty from the next cycle

`timescale 1ns/100ps
`default_nettype none

module cpl_req_fifo #(
   parameter int FIFO_DEPTH = 4,
   parameter int MEM_AW     = 6
) (
   input  logic                clk_in,
   input  logic                rstn,
   input  logic                push,
   input  rp_pkg::tag_t        req_tag,
   input  rp_pkg::req_id_t     req_id,
   input  logic [MEM_AW-1:0]   req_line,
   input  rp_pkg::len_dw_t     req_len,
   input  logic                pop,
   output logic                full,
   output logic                not_empty,
   output rp_pkg::tag_t        head_tag,
   output rp_pkg::req_id_t     head_id,
   output logic [MEM_AW-1:0]   head_line,
   output rp_pkg::len_dw_t     head_len
);

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   rp_pkg::tag_t        tag_q  [FIFO_DEPTH];
   rp_pkg::req_id_t     id_q   [FIFO_DEPTH];
   logic [MEM_AW-1:0]   line_q [FIFO_DEPTH];
   rp_pkg::len_dw_t     len_q  [FIFO_DEPTH];
   logic [PTR_W-1:0]    wr_ptr;
   logic [PTR_W-1:0]    rd_ptr;
   logic [CNT_W-1:0]    count;
   logic                do_push;
   logic                do_pop;

   // Pointer step with wrap, depth need not be a power of two
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign full      = (count == CNT_W'(FIFO_DEPTH));
   assign not_empty = (count != '0);
   assign do_push   = push && !full;
   assign do_pop    = pop && not_empty;

   assign head_tag  = tag_q[rd_ptr];
   assign head_id   = id_q[rd_ptr];
   assign head_line = line_q[rd_ptr];
   assign head_len  = len_q[rd_ptr];

   always_ff @(posedge clk_in)
   begin
      if (!rstn)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= ptr_inc(wr_ptr);
         if (do_pop)
            rd_ptr <= ptr_inc(rd_ptr);
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Entry storage
   always_ff @(posedge clk_in)
   begin
      if (do_push)
      begin
         tag_q[wr_ptr]  <= req_tag;
         id_q[wr_ptr]   <= req_id;
         line_q[wr_ptr] <= req_line;
         len_q[wr_ptr]  <= req_len;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/rp_pkg.sv ====
// Shared widths and types for the root-port VC endpoint
// Stream beats are 128 bits and carry four dwords, DW0 in the low bits
// Only 3DW memory read, memory write and completion-with-data are encoded
// Payload lengths are whole memory lines, at most MAX_LEN_DW dwords

`default_nettype none

package rp_pkg;

   // ------------------------------------------------------------
   // Widths
   // ------------------------------------------------------------
   localparam int DATA_W     = 128;
   localparam int DW_W       = 32;
   localparam int LINE_DW    = 4;
   localparam int MAX_LEN_DW = 16;

   // ------------------------------------------------------------
   // TLP fmt/type byte, header DW0 bits 31:24
   // ------------------------------------------------------------
   typedef enum logic [7:0] {
      FT_MRD32 = 8'h00,
      FT_MWR32 = 8'h40,
      FT_CPLD  = 8'h4A
   } tlp_fmt_type_e;

   // ------------------------------------------------------------
   // Field types
   // ------------------------------------------------------------
   // One stream beat or one memory line
   typedef logic [DATA_W-1:0] beat_t;

   // Length field of DW0, in dwords
   typedef logic [9:0] len_dw_t;

   // Tag from DW1 of a request
   typedef logic [7:0] tag_t;

   // Requester or completer ID
   typedef logic [15:0] req_id_t;

   // Data beats of one TLP, 1 to 4
   typedef logic [2:0] beats_t;

endpackage

`default_nettype wire

// ==== rtl/rp_vc_intf.sv ====
// Root-port VC endpoint top level, 128-bit Avalon-ST rx and tx streams
// Memory writes land in the target memory, memory reads return CplD in order
// No credit checks, byte enables or ECRC, and only completions are sent
// MEM_AW sets the line address width, FIFO_DEPTH the number of queued reads

`timescale 1ns/100ps
`default_nettype none

module rp_vc_intf #(
   parameter int              MEM_AW       = 6,
   parameter int              FIFO_DEPTH   = 4,
   parameter rp_pkg::req_id_t COMPLETER_ID = 16'h0100
) (
   input  logic            clk_in,
   input  logic            rstn,
   input  logic            rx_st_valid,
   input  logic            rx_st_sop,
   input  logic            rx_st_eop,
   input  rp_pkg::beat_t   rx_st_data,
   input  logic            tx_st_ready,
   output logic            rx_st_ready,
   output logic            rx_err,
   output logic            tx_st_valid,
   output logic            tx_st_sop,
   output logic            tx_st_eop,
   output rp_pkg::beat_t   tx_st_data
);

   // Decoder to memory
   logic                wr_en;
   logic [MEM_AW-1:0]   wr_line;
   rp_pkg::beat_t       wr_data;

   // Decoder to queue
   logic                push;
   logic                full;
   rp_pkg::tag_t        req_tag;
   rp_pkg::req_id_t     req_id;
   logic [MEM_AW-1:0]   req_line;
   rp_pkg::len_dw_t     req_len;

   // Queue to builder
   logic                pop;
   logic                not_empty;
   rp_pkg::tag_t        head_tag;
   rp_pkg::req_id_t     head_id;
   logic [MEM_AW-1:0]   head_line;
   rp_pkg::len_dw_t     head_len;

   // Builder to memory
   logic                rd_en;
   logic [MEM_AW-1:0]   rd_line;
   rp_pkg::beat_t       rd_data;

   rx_tlp_decoder #(
      .MEM_AW (MEM_AW)
   ) i_rx_tlp_decoder (
      .clk_in      (clk_in),
      .rstn        (rstn),
      .rx_st_valid (rx_st_valid),
      .rx_st_sop   (rx_st_sop),
      .rx_st_eop   (rx_st_eop),
      .rx_st_data  (rx_st_data),
      .full        (full),
      .rx_st_ready (rx_st_ready),
      .rx_err      (rx_err),
      .wr_en       (wr_en),
      .wr_line     (wr_line),
      .wr_data     (wr_data),
      .push        (push),
      .req_tag     (req_tag),
      .req_id      (req_id),
      .req_line    (req_line),
      .req_len     (req_len)
   );

   cpl_req_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH),
      .MEM_AW     (MEM_AW)
   ) i_cpl_req_fifo (
      .clk_in    (clk_in),
      .rstn      (rstn),
      .push      (push),
      .req_tag   (req_tag),
      .req_id    (req_id),
      .req_line  (req_line),
      .req_len   (req_len),
      .pop       (pop),
      .full      (full),
      .not_empty (not_empty),
      .head_tag  (head_tag),
      .head_id   (head_id),
      .head_line (head_line),
      .head_len  (head_len)
   );

   target_mem #(
      .MEM_AW (MEM_AW)
   ) i_target_mem (
      .clk_in  (clk_in),
      .wr_en   (wr_en),
      .wr_line (wr_line),
      .wr_data (wr_data),
      .rd_en   (rd_en),
      .rd_line (rd_line),
      .rd_data (rd_data)
   );

   tx_cpl_builder #(
      .MEM_AW       (MEM_AW),
      .COMPLETER_ID (COMPLETER_ID)
   ) i_tx_cpl_builder (
      .clk_in      (clk_in),
      .rstn        (rstn),
      .not_empty   (not_empty),
      .head_tag    (head_tag),
      .head_id     (head_id),
      .head_line   (head_line),
      .head_len    (head_len),
      .rd_data     (rd_data),
      .tx_st_ready (tx_st_ready),
      .pop         (pop),
      .rd_en       (rd_en),
      .rd_line     (rd_line),
      .tx_st_valid (tx_st_valid),
      .tx_st_sop   (tx_st_sop),
      .tx_st_eop   (tx_st_eop),
      .tx_st_data  (tx_st_data)
   );

endmodule

`default_nettype wire

// ==== rtl/rx_tlp_decoder.sv ====
// Receive TLP decoder on the Avalon-ST style rx stream
// Accepts 3DW MWr and MRd with 16-byte aligned address and 4/8/12/16 DW length
// Any other TLP is consumed and dropped with a one-cycle rx_err pulse
// A header is only taken while the completion queue has room
// Address bits above the memory size are ignored, so lines wrap

`timescale 1ns/100ps
`default_nettype none

module rx_tlp_decoder #(
   parameter int MEM_AW = 6
) (
   input  logic                clk_in,
   input  logic                rstn,
   input  logic                rx_st_valid,
   input  logic                rx_st_sop,
   input  logic                rx_st_eop,
   input  rp_pkg::beat_t       rx_st_data,
   input  logic                full,
   output logic                rx_st_ready,
   output logic                rx_err,
   output logic                wr_en,
   output logic [MEM_AW-1:0]   wr_line,
   output rp_pkg::beat_t       wr_data,
   output logic                push,
   output rp_pkg::tag_t        req_tag,
   output rp_pkg::req_id_t     req_id,
   output logic [MEM_AW-1:0]   req_line,
   output rp_pkg::len_dw_t     req_len
);

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_WRITE,
      RX_DROP
   } rx_state_e;

   rx_state_e                 state;
   logic [MEM_AW-1:0]         line_ptr;
   rp_pkg::beats_t            beats_left;
   logic                      beat_xfer;
   logic                      hdr_xfer;
   logic [rp_pkg::DW_W-1:0]   hdr_dw0;
   logic [rp_pkg::DW_W-1:0]   hdr_dw1;
   logic [rp_pkg::DW_W-1:0]   hdr_dw2;
   rp_pkg::len_dw_t           hdr_len;
   logic                      len_ok;
   logic                      addr_ok;
   logic                      wr_ok;
   logic                      rd_ok;
   logic                      err_next;

   // ------------------------------------------------------------
   // Header fields, valid on a sop beat
   // ------------------------------------------------------------
   assign hdr_dw0 = rx_st_data[0 +: rp_pkg::DW_W];
   assign hdr_dw1 = rx_st_data[rp_pkg::DW_W +: rp_pkg::DW_W];
   assign hdr_dw2 = rx_st_data[2*rp_pkg::DW_W +: rp_pkg::DW_W];
   assign hdr_len = hdr_dw0[9:0];

   assign len_ok  = (hdr_len != '0) && (hdr_len <= rp_pkg::MAX_LEN_DW) &&
                    ((hdr_len % rp_pkg::LINE_DW) == 0);
   assign addr_ok = (hdr_dw2[3:0] == 4'h0);

   // A write must carry data beats, a read must end on its header
   assign wr_ok = (hdr_dw0[31:24] == rp_pkg::FT_MWR32) && len_ok && addr_ok && !rx_st_eop;
   assign rd_ok = (hdr_dw0[31:24] == rp_pkg::FT_MRD32) && len_ok && addr_ok && rx_st_eop;

   assign rx_st_ready = (state == RX_IDLE) ? !full : 1'b1;
   assign beat_xfer   = rx_st_valid && rx_st_ready;
   assign hdr_xfer    = beat_xfer && rx_st_sop && (state == RX_IDLE);

   // Completion request, pushed on the edge the read header transfers
   assign push     = hdr_xfer && rd_ok;
   assign req_tag  = hdr_dw1[15:8];
   assign req_id   = hdr_dw1[31:16];
   assign req_line = hdr_dw2[4 +: MEM_AW];
   assign req_len  = hdr_len;

   // Payload goes straight to the memory
   assign wr_en   = beat_xfer && (state == RX_WRITE);
   assign wr_line = line_ptr;
   assign wr_data = rx_st_data;

   // Bad header, or eop out of step with the length
   always_comb
   begin
      err_next = 1'b0;
      case (state)
         RX_IDLE:  err_next = hdr_xfer && !wr_ok && !rd_ok;
         RX_WRITE: err_next = beat_xfer && (rx_st_eop != (beats_left == 3'd1));
         default:  err_next = 1'b0;
      endcase
   end

   // ------------------------------------------------------------
   // FSM
   // ------------------------------------------------------------
   always_ff @(posedge clk_in)
   begin
      if (!rstn)
      begin
         state      <= RX_IDLE;
         rx_err     <= 1'b0;
         beats_left <= '0;
      end
      else
      begin
         rx_err <= err_next;
         case (state)
            RX_IDLE:
            begin
               if (hdr_xfer && wr_ok)
               begin
                  state      <= RX_WRITE;
                  beats_left <= rp_pkg::beats_t'(hdr_len / rp_pkg::LINE_DW);
               end
               else if (hdr_xfer && !rd_ok && !rx_st_eop)
               begin
                  state <= RX_DROP;
               end
            end
            RX_WRITE:
            begin
               if (beat_xfer)
               begin
                  beats_left <= beats_left - 3'd1;
                  if (rx_st_eop)
                     state <= RX_IDLE;
                  // Length used up but the packet goes on
                  else if (beats_left == 3'd1)
                     state <= RX_DROP;
               end
            end
            RX_DROP:
            begin
               if (beat_xfer && rx_st_eop)
                  state <= RX_IDLE;
            end
            default: state <= RX_IDLE;
         endcase
      end
   end

   // Line pointer
   always_ff @(posedge clk_in)
   begin
      if (hdr_xfer)
         line_ptr <= hdr_dw2[4 +: MEM_AW];
      else if (wr_en)
         line_ptr <= line_ptr + 1'b1;
   end

endmodule

`default_nettype wire

// ==== rtl/target_mem.sv ====
// Target memory, one 128-bit line per address
// Single write port and a registered read port
// A read and a write to the same line on one edge return the old line
// No reset, contents are undefined until written

`timescale 1ns/100ps
`default_nettype none

module target_mem #(
   parameter int MEM_AW = 6
) (
   input  logic                clk_in,
   input  logic                wr_en,
   input  logic [MEM_AW-1:0]   wr_line,
   input  rp_pkg::beat_t       wr_data,
   input  logic                rd_en,
   input  logic [MEM_AW-1:0]   rd_line,
   output rp_pkg::beat_t       rd_data
);

   localparam int DEPTH = 1 << MEM_AW;

   rp_pkg::beat_t mem [DEPTH];

   // Write port
   always_ff @(posedge clk_in)
   begin
      if (wr_en)
      begin
         mem[wr_line] <= wr_data;
      end
   end

   // Read port, holds its last value while rd_en is low
   always_ff @(posedge clk_in)
   begin
      if (rd_en)
      begin
         rd_data <= mem[rd_line];
      end
   end

endmodule

`default_nettype wire

// ==== rtl/tx_cpl_builder.sv ====
// Completion builder on the Avalon-ST style tx stream
// Sends one CplD per queued request, successful status, lower address 0
// Header beat one cycle after pop, each data beat two cycles after the last transfer
// All tx outputs hold while tx_st_valid is high and tx_st_ready is low
// Request lengths are assumed already checked, 1 to 4 full lines

`timescale 1ns/100ps
`default_nettype none

module tx_cpl_builder #(
   parameter int              MEM_AW       = 6,
   parameter rp_pkg::req_id_t COMPLETER_ID = 16'h0100
) (
   input  logic                clk_in,
   input  logic                rstn,
   input  logic                not_empty,
   input  rp_pkg::tag_t        head_tag,
   input  rp_pkg::req_id_t     head_id,
   input  logic [MEM_AW-1:0]   head_line,
   input  rp_pkg::len_dw_t     head_len,
   input  rp_pkg::beat_t       rd_data,
   input  logic                tx_st_ready,
   output logic                pop,
   output logic                rd_en,
   output logic [MEM_AW-1:0]   rd_line,
   output logic                tx_st_valid,
   output logic                tx_st_sop,
   output logic                tx_st_eop,
   output rp_pkg::beat_t       tx_st_data
);

   typedef enum logic [1:0] {
      TX_IDLE,
      TX_HDR,
      TX_READ,
      TX_DATA
   } tx_state_e;

   tx_state_e                 state;
   logic [MEM_AW-1:0]         line_ptr;
   rp_pkg::beats_t            beats_left;
   logic [11:0]               byte_cnt;
   logic [rp_pkg::DW_W-1:0]   cpl_dw0;
   logic [rp_pkg::DW_W-1:0]   cpl_dw1;
   logic [rp_pkg::DW_W-1:0]   cpl_dw2;

   // ------------------------------------------------------------
   // Completion header from the queue head
   // ------------------------------------------------------------
   assign byte_cnt = {head_len, 2'b00};
   assign cpl_dw0  = {rp_pkg::FT_CPLD, 14'h0, head_len};
   // Status 000, BCM clear
   assign cpl_dw1  = {COMPLETER_ID, 3'b000, 1'b0, byte_cnt};
   assign cpl_dw2  = {head_id, head_tag, 1'b0, 7'h00};

   assign pop     = (state == TX_IDLE) && not_empty;
   assign rd_en   = (state == TX_READ);
   assign rd_line = line_ptr;

   // ------------------------------------------------------------
   // FSM
   // ------------------------------------------------------------
   always_ff @(posedge clk_in)
   begin
      if (!rstn)
      begin
         state       <= TX_IDLE;
         tx_st_valid <= 1'b0;
         tx_st_sop   <= 1'b0;
         tx_st_eop   <= 1'b0;
         beats_left  <= '0;
      end
      else
      begin
         case (state)
            TX_IDLE:
            begin
               if (not_empty)
               begin
                  state       <= TX_HDR;
                  tx_st_valid <= 1'b1;
                  tx_st_sop   <= 1'b1;
                  tx_st_eop   <= 1'b0;
                  beats_left  <= rp_pkg::beats_t'(head_len / rp_pkg::LINE_DW);
               end
            end
            TX_HDR:
            begin
               if (tx_st_ready)
               begin
                  state       <= TX_READ;
                  tx_st_valid <= 1'b0;
                  tx_st_sop   <= 1'b0;
               end
            end
            // Memory returns the line at the end of this cycle
            TX_READ: state <= TX_DATA;
            TX_DATA:
            begin
               if (!tx_st_valid)
               begin
                  // Capture cycle
                  tx_st_valid <= 1'b1;
                  tx_st_eop   <= (beats_left == 3'd1);
               end
               else if (tx_st_ready)
               begin
                  tx_st_valid <= 1'b0;
                  tx_st_eop   <= 1'b0;
                  beats_left  <= beats_left - 3'd1;
                  state       <= tx_st_eop ? TX_IDLE : TX_READ;
               end
            end
            default: state <= TX_IDLE;
         endcase
      end
   end

   // ------------------------------------------------------------
   // Beat data and line pointer
   // ------------------------------------------------------------
   always_ff @(posedge clk_in)
   begin
      if (pop)
      begin
         tx_st_data <= {{rp_pkg::DW_W{1'b0}}, cpl_dw2, cpl_dw1, cpl_dw0};
         line_ptr   <= head_line;
      end
      if (rd_en)
         line_ptr <= line_ptr + 1'b1;
      if ((state == TX_DATA) && !tx_st_valid)
         tx_st_data <= rd_data;
   end

endmodule

`default_nettype wire

// ==== tests/rp_vc_intf_sva.sv ====
// Stream protocol assertions, bound into the endpoint top level
// Reset is synchronous and active low, as in the design
// Checks only the tx stream outputs and the rx_err pulse

`timescale 1ns/100ps
`default_nettype none

module rp_vc_intf_sva (
   input logic            clk_in,
   input logic            rstn,
   input logic            tx_st_valid,
   input logic            tx_st_ready,
   input logic            tx_st_sop,
   input logic            tx_st_eop,
   input rp_pkg::beat_t   tx_st_data,
   input logic            rx_err
);

   // Outputs idle after a reset edge
   a_reset_idle: assert property (@(posedge clk_in)
      !rstn |=> !tx_st_valid && !tx_st_sop && !tx_st_eop)
      else $error("tx stream not idle after reset");

   // A stalled beat holds
   a_stall_hold: assert property (@(posedge clk_in) disable iff (!rstn)
      tx_st_valid && !tx_st_ready |=> tx_st_valid && $stable(tx_st_sop) &&
      $stable(tx_st_eop) && $stable(tx_st_data))
      else $error("tx beat changed under back-pressure");

   a_sop_valid: assert property (@(posedge clk_in) disable iff (!rstn)
      tx_st_sop |-> tx_st_valid)
      else $error("tx_st_sop without tx_st_valid");

   a_eop_valid: assert property (@(posedge clk_in) disable iff (!rstn)
      tx_st_eop |-> tx_st_valid)
      else $error("tx_st_eop without tx_st_valid");

   a_err_pulse: assert property (@(posedge clk_in) disable iff (!rstn)
      rx_err |=> !rx_err)
      else $error("rx_err high for two cycles");

endmodule

bind rp_vc_intf rp_vc_intf_sva i_sva (
   .clk_in      (clk_in),
   .rstn        (rstn),
   .tx_st_valid (tx_st_valid),
   .tx_st_ready (tx_st_ready),
   .tx_st_sop   (tx_st_sop),
   .tx_st_eop   (tx_st_eop),
   .tx_st_data  (tx_st_data),
   .rx_err      (rx_err)
);

`default_nettype wire

// ==== tests/rp_vc_intf_tb.sv ====
// Testbench for the root-port VC endpoint, default parameters
// Records come from tests/rp_vc_intf_tests.txt, so run it from the project root
// Write data DW k of a record is its seed plus k
// Expected completions are taken from a model memory when the read is sent
// Reads in a random-stall group must not cover lines written later in the group

`timescale 1ns/100ps
`default_nettype none

module rp_vc_intf_tb;

   localparam int          MEM_LINES = 64;
   localparam int          MAX_RECS  = 64;
   localparam int          TMO       = 2000;
   localparam logic [15:0] CPL_ID    = 16'h0100;

   typedef struct packed {
      int                  idx;
      logic [7:0]          tag;
      logic [15:0]         id;
      logic [9:0]          len;
      logic [3:0][127:0]   data;
   } cpl_t;

   logic            clk_in;
   logic            rstn;
   logic            rx_st_valid;
   logic            rx_st_sop;
   logic            rx_st_eop;
   rp_pkg::beat_t   rx_st_data;
   logic            tx_st_ready;
   logic            rx_st_ready;
   logic            rx_err;
   logic            tx_st_valid;
   logic            tx_st_sop;
   logic            tx_st_eop;
   rp_pkg::beat_t   tx_st_data;

   logic [79:0]     recs [MAX_RECS];
   logic [127:0]    model_mem [MEM_LINES];
   string           names [MAX_RECS];
   bit              test_bad [MAX_RECS];
   cpl_t            exp_q [$];
   cpl_t            cur;
   bit              in_pkt;
   int              beat_idx;
   int              n_recs;
   int              n_failed;
   int              errors;
   int              err_seen;
   int              tx_mode;
   int              seed;

   rp_vc_intf i_dut (
      .clk_in      (clk_in),
      .rstn        (rstn),
      .rx_st_valid (rx_st_valid),
      .rx_st_sop   (rx_st_sop),
      .rx_st_eop   (rx_st_eop),
      .rx_st_data  (rx_st_data),
      .tx_st_ready (tx_st_ready),
      .rx_st_ready (rx_st_ready),
      .rx_err      (rx_err),
      .tx_st_valid (tx_st_valid),
      .tx_st_sop   (tx_st_sop),
      .tx_st_eop   (tx_st_eop),
      .tx_st_data  (tx_st_data)
   );

   always #5 clk_in = ~clk_in;

   // ------------------------------------------------------------
   // Helpers
   // ------------------------------------------------------------
   task automatic check_value(input int idx, input string what,
                              input logic [127:0] exp, input logic [127:0] act);
      if (act !== exp)
      begin
         $display("MISMATCH %s %s expected %0h actual %0h", names[idx], what, exp, act);
         test_bad[idx] = 1'b1;
         errors++;
      end
   endtask

   task automatic note_failure(input string why);
      $display("ERROR %s", why);
      errors++;
   endtask

   task automatic abort_on_timeout(input string what);
      $display("TIMEOUT no progress while waiting for %s", what);
      $display("Verification failed");
      $finish;
   endtask

   task automatic report_test(input int idx);
      $display("%-24s %s", names[idx], test_bad[idx] ? "FAIL" : "pass");
   endtask

   function automatic bit op_known(input logic [7:0] op);
      return (op == "W") || (op == "R") || (op == "U");
   endfunction

   // Header rules of the receive side
   function automatic bit hdr_ok(input logic [7:0] op, input logic [11:0] addr,
                                 input logic [9:0] len);
      return ((op == "W") || (op == "R")) && (addr[3:0] == 4'h0) &&
             ((len == 4) || (len == 8) || (len == 12) || (len == 16));
   endfunction

   // One beat on the rx stream, called 1 ns after an edge
   task automatic send_beat(input rp_pkg::beat_t data, input logic sop, input logic eop);
      bit taken;
      int waited;
      taken       = 1'b0;
      waited      = 0;
      rx_st_valid = 1'b1;
      rx_st_sop   = sop;
      rx_st_eop   = eop;
      rx_st_data  = data;
      while (!taken)
      begin
         // Ready does not depend on valid, this is its value at the coming edge
         taken = rx_st_ready;
         @(posedge clk_in);
         #1;
         waited++;
         if (!taken && (waited > TMO))
            abort_on_timeout("rx_st_ready");
      end
      rx_st_valid = 1'b0;
      rx_st_sop   = 1'b0;
      rx_st_eop   = 1'b0;
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while ((exp_q.size() != 0) || in_pkt)
      begin
         @(posedge clk_in);
         #1;
         waited++;
         if (waited > TMO)
            abort_on_timeout("pending completions");
      end
   endtask

   // ------------------------------------------------------------
   // Send one record and update the model
   // ------------------------------------------------------------
   task automatic send_record(input int idx);
      logic [7:0]    op;
      logic [11:0]   addr;
      logic [7:0]    len;
      logic [7:0]    tag;
      logic [31:0]   dseed;
      logic [3:0]    beats;
      logic [3:0]    exp_err;
      logic [3:0]    mode;
      logic [7:0]    ftype;
      logic [15:0]   rid;
      rp_pkg::beat_t beat;
      cpl_t          c;
      int            errs_before;
      int            line;
      {op, addr, len, tag, dseed, beats, exp_err, mode} = recs[idx];
      names[idx] = $sformatf("t%0d_%s_%03h_len%0d", idx, op, addr, len);
      rid        = 16'h0800 + 16'(idx);
      ftype      = (op == "W") ? 8'h40 : (op == "R") ? 8'h00 : 8'h04;
      tx_mode    = int'(mode);
      errs_before = err_seen;

      beat = {32'h0, 20'h0, addr, rid, tag, 8'hFF, ftype, 14'h0, 2'b00, len};
      send_beat(beat, 1'b1, beats == 0);

      if (hdr_ok(op, addr, {2'b00, len}) && (op == "R"))
      begin
         c.idx  = idx;
         c.tag  = tag;
         c.id   = rid;
         c.len  = {2'b00, len};
         c.data = '0;
         for (int b = 0; b < int'(len) / 4; b++)
         begin
            line      = (int'(addr >> 4) + b) % MEM_LINES;
            c.data[b] = model_mem[line];
         end
         exp_q.push_back(c);
      end

      for (int b = 0; b < int'(beats); b++)
      begin
         for (int j = 0; j < 4; j++)
            beat[32*j +: 32] = dseed + 32'(4 * b + j);
         send_beat(beat, 1'b0, b == int'(beats) - 1);
         // Write stops at the eop or at the end of the length
         if (hdr_ok(op, addr, {2'b00, len}) && (op == "W") && (b < int'(len) / 4))
         begin
            line            = (int'(addr >> 4) + b) % MEM_LINES;
            model_mem[line] = beat;
         end
      end

      // rx_err comes one cycle after the offending beat
      repeat (2) @(posedge clk_in);
      #1;
      check_value(idx, "rx_err pulses", 128'(exp_err), 128'(err_seen - errs_before));

      if (mode == 4'd3)
      begin
         check_value(idx, "rx_st_ready with queue full", 128'(0), 128'(rx_st_ready));
         tx_mode = 0;
      end
      if ((mode == 4'd0) || (mode == 4'd3))
         wait_drain();
      if (!(hdr_ok(op, addr, {2'b00, len}) && (op == "R")))
         report_test(idx);
   endtask

   // ------------------------------------------------------------
   // tx_st_ready and monitors
   // ------------------------------------------------------------
   always @(posedge clk_in)
   begin
      #1;
      if (tx_mode == 1)
         tx_st_ready = (($random(seed) % 3) != 0);
      else
         tx_st_ready = (tx_mode == 0);
   end

   always @(posedge clk_in)
   begin
      if (rstn && rx_err)
         err_seen++;
   end

   always @(posedge clk_in)
   begin
      if (rstn && tx_st_valid && tx_st_ready)
      begin
         if (tx_st_sop)
         begin
            if (in_pkt)
               note_failure("completion header inside a completion");
            if (exp_q.size() == 0)
            begin
               note_failure("completion sent with no pending read");
               in_pkt = 1'b0;
            end
            else
            begin
               cur      = exp_q.pop_front();
               in_pkt   = 1'b1;
               beat_idx = 0;
               check_value(cur.idx, "fmt/type", 128'h4A, 128'(tx_st_data[31:24]));
               check_value(cur.idx, "length", 128'(cur.len), 128'(tx_st_data[9:0]));
               check_value(cur.idx, "completer id", 128'(CPL_ID), 128'(tx_st_data[63:48]));
               check_value(cur.idx, "status", 128'(0), 128'(tx_st_data[47:45]));
               check_value(cur.idx, "byte count", 128'(4 * int'(cur.len)),
                           128'(tx_st_data[43:32]));
               check_value(cur.idx, "requester id", 128'(cur.id), 128'(tx_st_data[95:80]));
               check_value(cur.idx, "tag", 128'(cur.tag), 128'(tx_st_data[79:72]));
               check_value(cur.idx, "lower address", 128'(0), 128'(tx_st_data[70:64]));
               check_value(cur.idx, "header eop", 128'(0), 128'(tx_st_eop));
            end
         end
         else if (!in_pkt)
            note_failure("completion data beat outside a completion");
         else
         begin
            check_value(cur.idx, $sformatf("data beat %0d", beat_idx),
                        cur.data[beat_idx], tx_st_data);
            check_value(cur.idx, $sformatf("eop on beat %0d", beat_idx),
                        128'(beat_idx == int'(cur.len) / 4 - 1), 128'(tx_st_eop));
            beat_idx++;
            if (tx_st_eop || (beat_idx == int'(cur.len) / 4))
            begin
               in_pkt = 1'b0;
               report_test(cur.idx);
            end
         end
      end
   end

   // ------------------------------------------------------------
   // Main sequence
   // ------------------------------------------------------------
   initial
   begin
      clk_in      = 1'b0;
      rstn        = 1'b0;
      rx_st_valid = 1'b0;
      rx_st_sop   = 1'b0;
      rx_st_eop   = 1'b0;
      rx_st_data  = '0;
      tx_st_ready = 1'b1;
      tx_mode     = 0;
      seed        = 81;
      errors      = 0;
      err_seen    = 0;
      in_pkt      = 1'b0;
      n_recs      = 0;
      n_failed    = 0;
      $readmemh("tests/rp_vc_intf_tests.txt", recs);

      repeat (8) @(posedge clk_in);
      #1;
      rstn = 1'b1;
      @(posedge clk_in);
      #1;

      while ((n_recs < MAX_RECS) && op_known(recs[n_recs][79:72]))
      begin
         send_record(n_recs);
         n_recs++;
      end
      tx_mode = 0;
      wait_drain();

      for (int i = 0; i < n_recs; i++)
         n_failed += int'(test_bad[i]);
      $display("tests %0d passed %0d failed %0d errors %0d",
               n_recs, n_recs - n_failed, n_failed, errors);
      if ((errors == 0) && (n_recs > 0))
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== tests/rp_vc_intf_tests.txt ====
// op_addr_len_tag_seed_beats_err_mode, all hex, op in ASCII: W=57 R=52 U=55
// mode 0 ready high, 1 random stalls, 2 ready low, 3 ready low then rx ready must be low
57_000_04_00_10000000_1_0_0
52_000_04_01_00000000_0_0_0
57_100_10_00_20000000_4_0_0
52_100_10_02_00000000_0_0_0
// Wraps from line 63 to line 0
57_3E0_10_00_30000000_4_0_0
52_3E0_10_03_00000000_0_0_0
// Unsupported type, length 6, unaligned address
55_200_04_04_00000000_0_1_0
57_200_06_00_40000000_2_1_0
52_104_04_05_00000000_0_1_0
57_200_04_00_50000000_1_0_0
52_200_04_06_00000000_0_0_0
// Early eop, one beat of two
57_240_08_00_60000000_1_1_0
52_240_04_07_00000000_0_0_0
// Back-pressure fills the queue
57_280_10_00_70000000_4_0_0
52_280_04_10_00000000_0_0_2
52_290_04_11_00000000_0_0_2
52_2A0_04_12_00000000_0_0_2
52_2B0_04_13_00000000_0_0_2
52_280_08_14_00000000_0_0_3
// Mixed traffic under random stalls
57_300_08_00_80000000_2_0_1
52_300_08_20_00000000_0_0_1
57_320_04_00_90000000_1_0_1
52_320_04_21_00000000_0_0_1
52_100_10_22_00000000_0_0_1
57_340_0C_00_A0000000_3_0_1
52_340_0C_23_00000000_0_0_1
52_000_04_24_00000000_0_0_1
// End marker
00_000_00_00_00000000_0_0_0
